// File: src/ospfb_types_pkg.sv
`default_nettype none

package ospfb_types_pkg;

  // one complex sample, real part in bits 31:16 and imaginary part in bits 15:0
  typedef logic [31:0] sample_t;

  // one signed component of a sample
  typedef logic signed [15:0] comp_t;

  // filter coefficient in Q1.15
  typedef logic signed [15:0] coeff_t;

  // per-component accumulator, 32-bit product plus growth over the taps
  typedef logic signed [35:0] acc_t;

  // branch number or output index within a frame
  typedef logic [2:0] branch_t;

  // rotator output side
  typedef enum logic [0:0] {
    ROT_IDLE,
    ROT_SEND
  } rot_state_t;

endpackage

`default_nettype wire

// File: src/ospfb_filter_pkg.sv
`default_nettype none

package ospfb_filter_pkg;

  // branches per frame, also the downstream FFT size
  localparam int FFT_LEN = 8;
  // new samples per frame
  localparam int DEC_FAC = 6;
  // taps per branch
  localparam int PTAPS = 4;
  localparam int NTAPS = FFT_LEN * PTAPS;

  // fraction bits of a coefficient
  localparam int COEFF_FRAC = 15;

  // lowpass prototype, symmetric
  // row p holds tap p of branches 0..7, so index is p*FFT_LEN + k
  // each column sums to well under 1.0 in magnitude, so no branch sum can overflow
  localparam ospfb_types_pkg::coeff_t TAPS [NTAPS] = '{
    -16'sd120,  -16'sd260,  -16'sd380,  -16'sd420,  -16'sd300,  16'sd0,     16'sd480,   16'sd1100,
    16'sd1800,  16'sd2900,  16'sd4200,  16'sd5600,  16'sd7000,  16'sd8200,  16'sd9100,  16'sd9600,
    16'sd9600,  16'sd9100,  16'sd8200,  16'sd7000,  16'sd5600,  16'sd4200,  16'sd2900,  16'sd1800,
    16'sd1100,  16'sd480,   16'sd0,     -16'sd300,  -16'sd420,  -16'sd380,  -16'sd260,  -16'sd120
  };

endpackage

`default_nettype wire

// File: src/axis_cdc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module axis_cdc_fifo #(
  parameter int FIFO_DEPTH = 16,
  parameter int SYNC_STAGES = 2,
  parameter int COUNT_WID = $clog2(FIFO_DEPTH) + 1
) (
  input wire logic clka,
  input wire logic clkb,
  input wire logic rst_n,

  // write side, adc clock
  input wire ospfb_types_pkg::sample_t s_axis_tdata,
  input wire logic s_axis_tvalid,
  input wire logic s_axis_tlast,
  output logic s_axis_tready,

  // read side, dsp clock
  output ospfb_types_pkg::sample_t m_axis_tdata,
  output logic m_axis_tvalid,
  output logic m_axis_tlast,
  input wire logic m_axis_tready,

  // write-side occupancy
  output logic [COUNT_WID-1:0] fill_count
);
  import ospfb_types_pkg::*;

  localparam int ADDR_WID = $clog2(FIFO_DEPTH);
  // one extra bit tells full from empty
  localparam int PTR_WID = ADDR_WID + 1;

  // storage, tlast in the top bit
  logic [$bits(sample_t):0] mem [FIFO_DEPTH];

  logic [PTR_WID-1:0] wr_bin, wr_bin_next, wr_gray, wr_gray_next;
  logic [PTR_WID-1:0] rd_bin, rd_bin_next, rd_gray, rd_gray_next;
  logic [PTR_WID-1:0] rq_sync [SYNC_STAGES];
  logic [PTR_WID-1:0] wq_sync [SYNC_STAGES];
  logic [PTR_WID-1:0] rq_last, wq_last, rq_bin, full_pat;
  logic full_r, empty_r;
  logic wr_fire, rd_fire;

  function automatic logic [PTR_WID-1:0] bin2gray(input logic [PTR_WID-1:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [PTR_WID-1:0] gray2bin(input logic [PTR_WID-1:0] g);
    logic [PTR_WID-1:0] b;
    b[PTR_WID-1] = g[PTR_WID-1];
    for (int i = PTR_WID - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // write side
  assign s_axis_tready = !full_r;
  assign wr_fire = s_axis_tvalid && s_axis_tready;
  assign wr_bin_next = wr_bin + PTR_WID'(wr_fire);
  assign wr_gray_next = bin2gray(wr_bin_next);
  assign rq_last = rq_sync[SYNC_STAGES-1];
  // full when the write pointer is one lap ahead, top two gray bits inverted
  assign full_pat = {~rq_last[PTR_WID-1 -: 2], rq_last[PTR_WID-3:0]};
  assign rq_bin = gray2bin(rq_last);
  assign fill_count = COUNT_WID'(wr_bin - rq_bin);

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      wr_bin <= '0;
      wr_gray <= '0;
      full_r <= 1'b0;
      rq_sync <= '{default: '0};
    end else begin
      wr_bin <= wr_bin_next;
      wr_gray <= wr_gray_next;
      full_r <= (wr_gray_next == full_pat);
      // read pointer into the adc domain
      rq_sync[0] <= rd_gray;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        rq_sync[i] <= rq_sync[i-1];
      end
    end
  end

  always_ff @(posedge clka) begin
    if (wr_fire) begin
      mem[wr_bin[ADDR_WID-1:0]] <= {s_axis_tlast, s_axis_tdata};
    end
  end

  // read side
  assign m_axis_tvalid = !empty_r;
  assign rd_fire = m_axis_tvalid && m_axis_tready;
  assign rd_bin_next = rd_bin + PTR_WID'(rd_fire);
  assign rd_gray_next = bin2gray(rd_bin_next);
  assign wq_last = wq_sync[SYNC_STAGES-1];
  assign {m_axis_tlast, m_axis_tdata} = mem[rd_bin[ADDR_WID-1:0]];

  always_ff @(posedge clkb or negedge rst_n) begin
    if (!rst_n) begin
      rd_bin <= '0;
      rd_gray <= '0;
      empty_r <= 1'b1;
      wq_sync <= '{default: '0};
    end else begin
      rd_bin <= rd_bin_next;
      rd_gray <= rd_gray_next;
      // registered empty adds the one edge after the synchronizer
      empty_r <= (rd_gray_next == wq_last);
      wq_sync[0] <= wr_gray;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        wq_sync[i] <= wq_sync[i-1];
      end
    end
  end

  // full flag lags the read pointer, so an accepted write always has room
  assert property (@(posedge clka) disable iff (!rst_n)
    wr_fire |-> fill_count < COUNT_WID'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: src/polyphase_fir.sv
`timescale 1ns/1ps
`default_nettype none

module polyphase_fir (
  input wire logic clk,
  input wire logic rst_n,

  // samples from the fifo
  input wire ospfb_types_pkg::sample_t s_axis_tdata,
  input wire logic s_axis_tvalid,
  input wire logic s_axis_tlast,
  output logic s_axis_tready,

  // one branch result per handshake, branches in order 0..FFT_LEN-1
  output ospfb_types_pkg::sample_t branch_tdata,
  output logic branch_tvalid,
  output ospfb_types_pkg::branch_t branch_index,
  input wire logic branch_tready,

  output logic event_tlast_missing,
  output logic event_tlast_unexpected
);
  import ospfb_types_pkg::*;
  import ospfb_filter_pkg::*;

  localparam int HIST_WID = $clog2(NTAPS);
  localparam int TAP_WID = $clog2(PTAPS);
  localparam int CNT_WID = $clog2(DEC_FAC);

  typedef enum logic [1:0] {
    FIR_COLLECT,
    FIR_MAC,
    FIR_HOLD
  } fir_state_t;

  fir_state_t state;

  // sample history ring, wr_ptr points at the next free slot
  sample_t hist [NTAPS];
  logic [HIST_WID-1:0] wr_ptr;
  // samples seen so far, saturating, anything older reads as zero
  logic [HIST_WID:0] hist_cnt;
  logic [CNT_WID-1:0] samp_cnt;
  logic [TAP_WID-1:0] tap;

  logic [HIST_WID-1:0] offset, rd_addr;
  logic tap_valid, last_tap;
  sample_t x;
  coeff_t coef;
  comp_t x_re, x_im;
  acc_t prod_re, prod_im, acc_re, acc_im;
  acc_t sum_re, sum_im, shr_re, shr_im;
  logic s_fire, frame_done;

  assign s_axis_tready = (state == FIR_COLLECT);
  assign s_fire = s_axis_tvalid && s_axis_tready;
  assign frame_done = s_fire && (samp_cnt == CNT_WID'(DEC_FAC - 1));
  assign branch_tvalid = (state == FIR_HOLD);

  // tap offset p*FFT_LEN + k, both sizes are powers of two
  assign offset = {tap, branch_index};
  // newest sample sits one below wr_ptr
  assign rd_addr = wr_ptr - offset - HIST_WID'(1);
  assign tap_valid = ({1'b0, offset} < hist_cnt);
  assign x = hist[rd_addr];
  assign x_re = tap_valid ? x[31:16] : '0;
  assign x_im = tap_valid ? x[15:0] : '0;
  assign coef = TAPS[offset];

  // shared complex-by-real multiply-accumulate
  assign prod_re = acc_t'(x_re) * acc_t'(coef);
  assign prod_im = acc_t'(x_im) * acc_t'(coef);
  assign sum_re = (tap == '0) ? prod_re : acc_re + prod_re;
  assign sum_im = (tap == '0) ? prod_im : acc_im + prod_im;
  assign shr_re = sum_re >>> COEFF_FRAC;
  assign shr_im = sum_im >>> COEFF_FRAC;
  assign last_tap = (tap == TAP_WID'(PTAPS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= FIR_COLLECT;
      wr_ptr <= '0;
      hist_cnt <= '0;
      samp_cnt <= '0;
      tap <= '0;
      branch_index <= '0;
      event_tlast_missing <= 1'b0;
      event_tlast_unexpected <= 1'b0;
    end else begin
      event_tlast_missing <= 1'b0;
      event_tlast_unexpected <= 1'b0;
      case (state)
        FIR_COLLECT: begin
          if (s_fire) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (hist_cnt < (HIST_WID + 1)'(NTAPS)) begin
              hist_cnt <= hist_cnt + 1'b1;
            end
            // framing follows the sample count, tlast is only checked
            if (frame_done) begin
              samp_cnt <= '0;
              tap <= '0;
              branch_index <= '0;
              event_tlast_missing <= !s_axis_tlast;
              state <= FIR_MAC;
            end else begin
              samp_cnt <= samp_cnt + 1'b1;
              event_tlast_unexpected <= s_axis_tlast;
            end
          end
        end
        FIR_MAC: begin
          tap <= last_tap ? '0 : tap + 1'b1;
          if (last_tap) begin
            state <= FIR_HOLD;
          end
        end
        FIR_HOLD: begin
          if (branch_tready) begin
            if (branch_index == branch_t'(FFT_LEN - 1)) begin
              state <= FIR_COLLECT;
            end else begin
              branch_index <= branch_index + 1'b1;
              state <= FIR_MAC;
            end
          end
        end
        default: state <= FIR_COLLECT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_fire) begin
      hist[wr_ptr] <= s_axis_tdata;
    end
    if (state == FIR_MAC) begin
      acc_re <= sum_re;
      acc_im <= sum_im;
      // keep the low 16 bits of the scaled sum
      if (last_tap) begin
        branch_tdata <= {shr_re[15:0], shr_im[15:0]};
      end
    end
  end

  // a branch offered to the rotator stays put until taken
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_tvalid && !branch_tready |=>
      branch_tvalid && $stable(branch_index) && $stable(branch_tdata));

endmodule

`default_nettype wire

// File: src/phase_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module phase_rotator (
  input wire logic clk,
  input wire logic rst_n,

  // branch results from the fir
  input wire ospfb_types_pkg::sample_t branch_tdata,
  input wire logic branch_tvalid,
  input wire ospfb_types_pkg::branch_t branch_index,
  output logic branch_tready,

  // rotated frame out, tuser is the output index
  output ospfb_types_pkg::sample_t m_axis_tdata,
  output logic m_axis_tvalid,
  output logic m_axis_tlast,
  output ospfb_types_pkg::branch_t m_axis_tuser,
  input wire logic m_axis_tready
);
  import ospfb_types_pkg::*;
  import ospfb_filter_pkg::*;

  // two frame halves, address is {half, branch}
  sample_t frame_buf [2*FFT_LEN];
  // shift captured with each half
  branch_t half_shift [2];
  logic [1:0] half_full;
  logic wr_half, rd_half;
  branch_t wr_shift, out_j, rd_branch;
  rot_state_t state;
  logic b_fire, m_fire, last_branch, last_out;

  assign branch_tready = !half_full[wr_half];
  assign b_fire = branch_tvalid && branch_tready;
  assign last_branch = (branch_index == branch_t'(FFT_LEN - 1));

  assign m_axis_tvalid = (state == ROT_SEND);
  assign m_fire = m_axis_tvalid && m_axis_tready;
  assign last_out = (out_j == branch_t'(FFT_LEN - 1));
  // (j + s) mod FFT_LEN falls out of the 3-bit wrap
  assign rd_branch = out_j + half_shift[rd_half];
  assign m_axis_tdata = frame_buf[{rd_half, rd_branch}];
  assign m_axis_tlast = m_axis_tvalid && last_out;
  assign m_axis_tuser = out_j;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_full <= '0;
      wr_half <= 1'b0;
      rd_half <= 1'b0;
      wr_shift <= '0;
      out_j <= '0;
      state <= ROT_IDLE;
    end else begin
      // fill side, a half closes on the last branch
      if (b_fire && last_branch) begin
        half_full[wr_half] <= 1'b1;
        wr_half <= !wr_half;
        // frame phase advances by DEC_FAC, wraps mod FFT_LEN
        wr_shift <= wr_shift + branch_t'(DEC_FAC);
      end
      case (state)
        ROT_IDLE: begin
          if (half_full[rd_half]) begin
            out_j <= '0;
            state <= ROT_SEND;
          end
        end
        ROT_SEND: begin
          if (m_fire) begin
            out_j <= last_out ? '0 : out_j + 1'b1;
            if (last_out) begin
              half_full[rd_half] <= 1'b0;
              rd_half <= !rd_half;
              // go straight on if the other half is already waiting
              state <= half_full[!rd_half] ? ROT_SEND : ROT_IDLE;
            end
          end
        end
        default: state <= ROT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (b_fire) begin
      frame_buf[{wr_half, branch_index}] <= branch_tdata;
    end
    if (b_fire && last_branch) begin
      half_shift[wr_half] <= wr_shift;
    end
  end

  // the half being read is never overwritten mid-frame
  assert property (@(posedge clk) disable iff (!rst_n)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tuser));

endmodule

`default_nettype wire

// File: src/ospfb_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module ospfb_frontend #(
  parameter int FIFO_DEPTH = 16,
  parameter int SYNC_STAGES = 2,
  parameter int COUNT_WID = $clog2(FIFO_DEPTH) + 1
) (
  // adc clock
  input wire logic clka,
  // dsp clock
  input wire logic clkb,
  input wire logic rst_n,

  // sample stream in, clka
  input wire ospfb_types_pkg::sample_t s_axis_tdata,
  input wire logic s_axis_tvalid,
  input wire logic s_axis_tlast,
  output logic s_axis_tready,

  // rotated frames out to the fft, clkb
  output ospfb_types_pkg::sample_t m_axis_tdata,
  output logic m_axis_tvalid,
  output logic m_axis_tlast,
  output ospfb_types_pkg::branch_t m_axis_tuser,
  input wire logic m_axis_tready,

  // status
  output logic [COUNT_WID-1:0] fill_count,
  output logic event_tlast_missing,
  output logic event_tlast_unexpected
);
  import ospfb_types_pkg::*;

  // fifo to fir
  sample_t fifo_tdata;
  logic fifo_tvalid;
  logic fifo_tlast;
  logic fifo_tready;

  // fir to rotator
  sample_t branch_tdata;
  logic branch_tvalid;
  branch_t branch_index;
  logic branch_tready;

  axis_cdc_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .SYNC_STAGES(SYNC_STAGES),
    .COUNT_WID(COUNT_WID)
  ) i_axis_cdc_fifo (
    .clka(clka),
    .clkb(clkb),
    .rst_n(rst_n),
    .s_axis_tdata(s_axis_tdata),
    .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tlast(s_axis_tlast),
    .s_axis_tready(s_axis_tready),
    .m_axis_tdata(fifo_tdata),
    .m_axis_tvalid(fifo_tvalid),
    .m_axis_tlast(fifo_tlast),
    .m_axis_tready(fifo_tready),
    .fill_count(fill_count)
  );

  // fir and rotator both run on the dsp clock
  polyphase_fir i_polyphase_fir (
    .clk(clkb),
    .rst_n(rst_n),
    .s_axis_tdata(fifo_tdata),
    .s_axis_tvalid(fifo_tvalid),
    .s_axis_tlast(fifo_tlast),
    .s_axis_tready(fifo_tready),
    .branch_tdata(branch_tdata),
    .branch_tvalid(branch_tvalid),
    .branch_index(branch_index),
    .branch_tready(branch_tready),
    .event_tlast_missing(event_tlast_missing),
    .event_tlast_unexpected(event_tlast_unexpected)
  );

  phase_rotator i_phase_rotator (
    .clk(clkb),
    .rst_n(rst_n),
    .branch_tdata(branch_tdata),
    .branch_tvalid(branch_tvalid),
    .branch_index(branch_index),
    .branch_tready(branch_tready),
    .m_axis_tdata(m_axis_tdata),
    .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tlast(m_axis_tlast),
    .m_axis_tuser(m_axis_tuser),
    .m_axis_tready(m_axis_tready)
  );

endmodule

`default_nettype wire

// File: verification/ospfb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ospfb_checker #(
  parameter int FIFO_DEPTH = 16,
  parameter int COUNT_WID = $clog2(FIFO_DEPTH) + 1
) (
  input wire logic clka,
  input wire logic clkb,
  input wire logic rst_n,
  // input handshake in the adc clock domain
  input wire ospfb_types_pkg::sample_t s_axis_tdata,
  input wire logic s_axis_tvalid,
  input wire logic s_axis_tlast,
  input wire logic s_axis_tready,
  // output handshake in the dsp clock domain
  input wire ospfb_types_pkg::sample_t m_axis_tdata,
  input wire logic m_axis_tvalid,
  input wire logic m_axis_tlast,
  input wire ospfb_types_pkg::branch_t m_axis_tuser,
  input wire logic m_axis_tready,
  input wire logic [COUNT_WID-1:0] fill_count,
  input wire logic event_tlast_missing,
  input wire logic event_tlast_unexpected,
  // compare event counts once the pipeline is drained
  input wire logic check_events,
  output int error_count,
  output int frames_in,
  output int frames_out,
  output int pending
);
  import ospfb_types_pkg::*;
  import ospfb_filter_pkg::*;

  // every accepted sample with index 0 the first after reset
  sample_t hist [$];
  // expected words in output order
  sample_t exp_q [$];
  int exp_missing;
  int exp_unexp;
  int seen_missing;
  int seen_unexp;
  int out_pos;

  assign pending = exp_q.size();

  // branch k of the frame whose newest sample is t
  function automatic sample_t branch_value(input int t, input int k);
    longint re;
    longint im;
    int idx;
    sample_t x;
    re = 0;
    im = 0;
    for (int p = 0; p < PTAPS; p++) begin
      idx = t - k - FFT_LEN * p;
      // samples before the first count as zero
      x = (idx >= 0) ? hist[idx] : '0;
      re += longint'($signed(x[31:16])) * longint'(TAPS[p * FFT_LEN + k]);
      im += longint'($signed(x[15:0])) * longint'(TAPS[p * FFT_LEN + k]);
    end
    re = re >>> COEFF_FRAC;
    im = im >>> COEFF_FRAC;
    return {re[15:0], im[15:0]};
  endfunction

  // output j carries branch (j + s) mod FFT_LEN
  task automatic push_frame();
    int t;
    int s;
    sample_t br [FFT_LEN];
    t = hist.size() - 1;
    s = (frames_in * DEC_FAC) % FFT_LEN;
    for (int k = 0; k < FFT_LEN; k++) begin
      br[k] = branch_value(t, k);
    end
    for (int j = 0; j < FFT_LEN; j++) begin
      exp_q.push_back(br[(j + s) % FFT_LEN]);
    end
    frames_in++;
  endtask

  task automatic check_word();
    sample_t want;
    if (exp_q.size() == 0) begin
      $display("unexpected output at %0t: a word came out with no frame pending", $time);
      error_count++;
    end else begin
      want = exp_q.pop_front();
      if (m_axis_tdata !== want) begin
        $display("MISMATCH at %0t: frame %0d index %0d data %h, expected %h",
                 $time, frames_out, out_pos, m_axis_tdata, want);
        error_count++;
      end
      if (m_axis_tuser !== branch_t'(out_pos) || m_axis_tlast !== (out_pos == FFT_LEN - 1)) begin
        $display("MISMATCH at %0t: frame %0d index %0d got tuser %0d tlast %b",
                 $time, frames_out, out_pos, m_axis_tuser, m_axis_tlast);
        error_count++;
      end
    end
    out_pos++;
    if (out_pos == FFT_LEN) begin
      out_pos = 0;
      frames_out++;
    end
  endtask

  // occupancy is bounded by the depth and by the samples of frames not yet out
  task automatic check_fill();
    int limit;
    limit = hist.size() - DEC_FAC * frames_out;
    if (limit > FIFO_DEPTH) begin
      limit = FIFO_DEPTH;
    end
    if (int'(fill_count) > limit) begin
      $display("MISMATCH at %0t: fill count %0d, expected at most %0d",
               $time, fill_count, limit);
      error_count++;
    end
  endtask

  task automatic check_after_drain();
    if (seen_missing != exp_missing) begin
      $display("MISMATCH at %0t: %0d missing-tlast events, expected %0d",
               $time, seen_missing, exp_missing);
      error_count++;
    end
    if (seen_unexp != exp_unexp) begin
      $display("MISMATCH at %0t: %0d unexpected-tlast events, expected %0d",
               $time, seen_unexp, exp_unexp);
      error_count++;
    end
    // every sample has been read and the read pointer has crossed back
    if (fill_count !== '0) begin
      $display("MISMATCH at %0t: fill count %0d with the pipeline drained, expected 0",
               $time, fill_count);
      error_count++;
    end
  endtask

  // frames are counted by samples and tlast only predicts events
  always @(posedge clka) begin
    if (rst_n) begin
      check_fill();
      if (s_axis_tvalid && s_axis_tready) begin
        if (hist.size() % DEC_FAC == DEC_FAC - 1) begin
          if (!s_axis_tlast) begin
            exp_missing++;
          end
        end else if (s_axis_tlast) begin
          exp_unexp++;
        end
        hist.push_back(s_axis_tdata);
        if (hist.size() % DEC_FAC == 0) begin
          push_frame();
        end
      end
    end
  end

  always @(posedge clkb) begin
    if (rst_n) begin
      // events are single-cycle pulses
      if (event_tlast_missing) begin
        seen_missing++;
      end
      if (event_tlast_unexpected) begin
        seen_unexp++;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        check_word();
      end
      if (check_events) begin
        check_after_drain();
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/ospfb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ospfb_tb;
  import ospfb_types_pkg::*;
  import ospfb_filter_pkg::*;

  localparam int FIFO_DEPTH = 16;
  localparam int SYNC_STAGES = 2;
  localparam int COUNT_WID = $clog2(FIFO_DEPTH) + 1;
  localparam int CLKA_NS = 100;
  localparam int CLKB_NS = 40;
  localparam int TOTAL_FRAMES = 56;
  // fir spends DEC_FAC collect cycles plus PTAPS+1 cycles per branch on clkb
  localparam int FIR_FRAME_NS = (DEC_FAC + FFT_LEN * (PTAPS + 1)) * CLKB_NS;
  localparam longint WATCHDOG_NS =
    longint'(TOTAL_FRAMES) * (12 * CLKA_NS + 2 * FIR_FRAME_NS) + 20000;

  logic clka;
  logic clkb;
  logic rst_n;
  sample_t s_axis_tdata;
  logic s_axis_tvalid;
  logic s_axis_tlast;
  logic s_axis_tready;
  sample_t m_axis_tdata;
  logic m_axis_tvalid;
  logic m_axis_tlast;
  branch_t m_axis_tuser;
  logic m_axis_tready;
  logic [COUNT_WID-1:0] fill_count;
  logic event_tlast_missing;
  logic event_tlast_unexpected;
  logic check_events;
  logic bp_en;
  logic [15:0] lfsr;
  logic [31:0] rdy_bits;
  int error_count;
  int frames_in;
  int frames_out;
  int pending;

  ospfb_frontend #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .SYNC_STAGES(SYNC_STAGES)
  ) i_ospfb_frontend (
    .clka(clka),
    .clkb(clkb),
    .rst_n(rst_n),
    .s_axis_tdata(s_axis_tdata),
    .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tlast(s_axis_tlast),
    .s_axis_tready(s_axis_tready),
    .m_axis_tdata(m_axis_tdata),
    .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tlast(m_axis_tlast),
    .m_axis_tuser(m_axis_tuser),
    .m_axis_tready(m_axis_tready),
    .fill_count(fill_count),
    .event_tlast_missing(event_tlast_missing),
    .event_tlast_unexpected(event_tlast_unexpected)
  );

  ospfb_checker #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .COUNT_WID(COUNT_WID)
  ) i_ospfb_checker (
    .clka(clka),
    .clkb(clkb),
    .rst_n(rst_n),
    .s_axis_tdata(s_axis_tdata),
    .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tlast(s_axis_tlast),
    .s_axis_tready(s_axis_tready),
    .m_axis_tdata(m_axis_tdata),
    .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tlast(m_axis_tlast),
    .m_axis_tuser(m_axis_tuser),
    .m_axis_tready(m_axis_tready),
    .fill_count(fill_count),
    .event_tlast_missing(event_tlast_missing),
    .event_tlast_unexpected(event_tlast_unexpected),
    .check_events(check_events),
    .error_count(error_count),
    .frames_in(frames_in),
    .frames_out(frames_out),
    .pending(pending)
  );

  // adc clock rising edges at 50 + 100n never meet a clkb edge
  initial begin
    clka = 1'b0;
    forever #(CLKA_NS / 2) clka = !clka;
  end

  initial begin
    clkb = 1'b0;
    forever #(CLKB_NS / 2) clkb = !clkb;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] draw(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  // fft side ready is random only while back-pressure is on
  always @(posedge clkb) begin
    if (bp_en) begin
      rdy_bits = draw(1);
      m_axis_tready <= rdy_bits[0];
    end else begin
      m_axis_tready <= 1'b1;
    end
  end

  // hold tvalid and data until the fifo takes them
  task automatic send_sample(input sample_t d, input logic last);
    s_axis_tdata <= d;
    s_axis_tlast <= last;
    s_axis_tvalid <= 1'b1;
    @(posedge clka);
    while (!s_axis_tready) begin
      @(posedge clka);
    end
    s_axis_tvalid <= 1'b0;
  endtask

  // wait for every expected frame and then let the checker compare events
  task automatic drain();
    @(negedge clkb);
    while (pending != 0) begin
      @(negedge clkb);
    end
    @(posedge clkb);
    check_events <= 1'b1;
    @(posedge clkb);
    check_events <= 1'b0;
    @(negedge clkb);
  endtask

  task automatic run_test(input int num, input string name, input int nframes,
                          input logic impulse, input logic gaps, input logic flips);
    logic [31:0] r;
    sample_t d;
    logic last;
    int err0;
    err0 = error_count;
    for (int i = 0; i < nframes * DEC_FAC; i++) begin
      if (impulse) begin
        // half scale on real and minus half on imaginary
        d = (i == 0) ? 32'h4000_C000 : '0;
      end else begin
        r = draw(32);
        d = r;
      end
      last = (i % DEC_FAC == DEC_FAC - 1);
      if (flips) begin
        r = draw(3);
        // about one sample in eight gets a wrong tlast
        if (r[2:0] == 3'd0) begin
          last = !last;
        end
      end
      if (gaps) begin
        r = draw(2);
        if (r[1:0] == 2'd3) begin
          @(posedge clka);
        end
      end
      send_sample(d, last);
    end
    drain();
    $display("test %0d %s: %0d frames, %0d errors", num, name, nframes,
             error_count - err0);
  endtask

  initial begin
    rst_n = 1'b0;
    s_axis_tdata = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    m_axis_tready = 1'b1;
    check_events = 1'b0;
    bp_en = 1'b0;
    lfsr = 16'd59662;
    repeat (4) @(posedge clka);
    // release between edges of both clocks
    #5;
    rst_n = 1'b1;
    @(posedge clka);
    run_test(1, "impulse", 8, 1'b1, 1'b0, 1'b0);
    run_test(2, "random", 16, 1'b0, 1'b0, 1'b0);
    // starts on frame 24 so the shifts run 0, 6, 4 and 2
    run_test(3, "rotation", 4, 1'b0, 1'b0, 1'b0);
    bp_en = 1'b1;
    run_test(4, "backpressure", 16, 1'b0, 1'b1, 1'b0);
    bp_en = 1'b0;
    run_test(5, "framing", 12, 1'b0, 1'b0, 1'b1);
    if (frames_out != frames_in) begin
      $display("frame count wrong: %0d frames in, %0d frames out", frames_in, frames_out);
    end
    $display("tests 5, frames %0d, errors %0d", frames_out, error_count);
    if (error_count == 0 && frames_out == frames_in) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run hung with %0d of %0d frames out", frames_out, TOTAL_FRAMES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
src/ospfb_types_pkg.sv
src/ospfb_filter_pkg.sv
src/axis_cdc_fifo.sv
src/polyphase_fir.sv
src/phase_rotator.sv
src/ospfb_frontend.sv
verification/ospfb_checker.sv
verification/ospfb_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := ospfb_tb
FLIST    := flist.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), log in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
